// ==== Bender.yml ====
package:
  name: tofHist

export_include_dirs:
  - src

sources:
  - files:
      - src/tofHistPkg.sv
      - src/binDecoder.sv
      - src/binMemory.sv
      - src/histUpdater.sv
      - src/peakFinder.sv
      - src/histSequencer.sv
      - src/tofHistTop.sv
  - target: test
    files:
      - tests/tofHistTb.sv

// ==== compile.f ====
+incdir+src
src/tofHistPkg.sv
src/binDecoder.sv
src/binMemory.sv
src/histUpdater.sv
src/peakFinder.sv
src/histSequencer.sv
src/tofHistTop.sv
tests/tofHistTb.sv

// ==== src/binDecoder.sv ====
`include "tofHist_consts.svh"

module binDecoder import tofHistPkg::*; (
    input  logic               clk,
    input  logic               res,
    input  phase_e             phase,
    input  logic [`CBIN_W-1:0] window,
    input  event_s             evIn,
    input  logic               evValid,
    input  logic               accept,
    output binOp_s             op,
    output logic               opValid,
    output logic               lastSeen
);

    logic               take;
    logic               keep;
    logic [`BIN_AW-1:0] nextBin;

    assign take = accept && evValid;
    assign lastSeen = take && evIn.last; // same cycle as the handshake

    always_comb begin
        if (phase == FINE_BUILD) begin
            keep = (evIn.ts.fine.tag == window); // outside the coarse peak -> dropped
            nextBin = evIn.ts.fine.bin;
        end else begin
            keep = 1'b1;
            nextBin = evIn.ts.coarse.bin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            opValid <= 1'b0;
        end else begin
            opValid <= take && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (take && keep) begin
            op.bin <= nextBin;
        end
    end

endmodule

// ==== src/binMemory.sv ====
`include "tofHist_consts.svh"

module binMemory (
    input  logic               clk,
    input  logic               res,
    input  logic [`BIN_AW-1:0] rdAddr,
    input  logic [`BIN_AW-1:0] wrAddr,
    input  logic [`CNT_W-1:0]  wrData,
    input  logic               wrEn,
    output logic [`CNT_W-1:0]  rdData
);

    logic [`CNT_W-1:0] mem [`NBINS];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, sees the array before a write on the same edge
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdData <= '0;
        end else begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== src/histSequencer.sv ====
`include "tofHist_consts.svh"

module histSequencer import tofHistPkg::*; (
    input  logic               clk,
    input  logic               res,
    input  logic               evValid,
    input  logic               lastSeen,
    input  logic               clearDone,
    input  logic               idle,
    input  logic               scanDone,
    input  logic [`BIN_AW-1:0] peakBin,
    input  logic [`CNT_W-1:0]  peakCount,
    input  logic               resReady,
    output phase_e             phase,
    output logic [`CBIN_W-1:0] window,
    output logic               accept,
    output logic               evReady,
    output logic               scanStart,
    output result_s            resOut,
    output logic               resValid
);

    logic building;
    logic draining; // last event taken, pipeline still busy

    assign building = (phase == COARSE_BUILD) || (phase == FINE_BUILD);
    assign evReady = building && !draining;
    assign accept = evValid && evReady;
    assign scanStart = building && draining && idle;
    assign resValid = (phase == REPORT);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= RESET_CLR;
            draining <= 1'b0;
        end else begin
            if (building && lastSeen) begin
                draining <= 1'b1;
            end else if (scanStart) begin
                draining <= 1'b0;
            end
            case (phase)
                RESET_CLR: begin
                    if (clearDone) phase <= COARSE_BUILD;
                end
                COARSE_BUILD: begin
                    if (scanStart) phase <= COARSE_SCAN;
                end
                COARSE_SCAN: begin
                    if (scanDone) phase <= FINE_CLR;
                end
                FINE_CLR: begin
                    if (clearDone) phase <= FINE_BUILD;
                end
                FINE_BUILD: begin
                    if (scanStart) phase <= FINE_SCAN;
                end
                FINE_SCAN: begin
                    if (scanDone) phase <= REPORT;
                end
                REPORT: begin
                    if (resReady) phase <= RESET_CLR; // next frame
                end
                default: phase <= RESET_CLR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((phase == COARSE_SCAN) && scanDone) begin
            window <= peakBin; // selects events for the fine pass
        end
        if ((phase == FINE_SCAN) && scanDone) begin
            resOut.cBin <= window;
            resOut.fBin <= peakBin;
            resOut.count <= peakCount;
        end
    end

endmodule

// ==== src/histUpdater.sv ====
`include "tofHist_consts.svh"

module histUpdater import tofHistPkg::*; (
    input  logic               clk,
    input  logic               res,
    input  phase_e             phase,
    input  binOp_s             op,
    input  logic               opValid,
    input  logic [`BIN_AW-1:0] scanAddr,
    output logic [`CNT_W-1:0]  scanData,
    output logic               clearDone,
    output logic               idle
);

    logic               inClear;
    logic               inScan;
    logic [`BIN_AW-1:0] clrAddr;
    logic               bValid;  // read data for bBin arrives this cycle
    logic [`BIN_AW-1:0] bBin;
    logic               wbValid; // last write, not yet visible to the read port
    logic [`BIN_AW-1:0] wbBin;
    logic [`CNT_W-1:0]  wbData;
    logic [`CNT_W-1:0]  base;
    logic [`BIN_AW-1:0] rdAddr;
    logic [`BIN_AW-1:0] wrAddr;
    logic [`CNT_W-1:0]  rdData;
    logic [`CNT_W-1:0]  wrData;
    logic               wrEn;

    assign inClear = (phase == RESET_CLR) || (phase == FINE_CLR);
    assign inScan = (phase == COARSE_SCAN) || (phase == FINE_SCAN);

    assign rdAddr = inScan ? scanAddr : op.bin; // peak finder owns the port while scanning
    assign scanData = rdData;

    // back-to-back hits on one bin would otherwise read the old count
    assign base = (wbValid && (wbBin == bBin)) ? wbData : rdData;

    always_comb begin
        if (inClear) begin
            wrEn = 1'b1;
            wrAddr = clrAddr;
            wrData = '0;
        end else begin
            wrEn = bValid;
            wrAddr = bBin;
            wrData = base + 1'b1;
        end
    end

    assign clearDone = inClear && (clrAddr == `NBINS - 1);
    assign idle = !opValid && !bValid;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clrAddr <= '0;
            bValid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            bValid <= opValid;
            wbValid <= bValid;
            if (clearDone) begin
                clrAddr <= '0;
            end else if (inClear) begin
                clrAddr <= clrAddr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        bBin <= op.bin;
        wbBin <= bBin;
        wbData <= wrData;
    end

    binMemory mem (
        .clk    (clk),
        .res    (res),
        .rdAddr (rdAddr),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrEn   (wrEn),
        .rdData (rdData)
    );

endmodule

// ==== src/peakFinder.sv ====
`include "tofHist_consts.svh"

module peakFinder (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    output logic [`BIN_AW-1:0] scanAddr,
    input  logic [`CNT_W-1:0]  scanData,
    output logic [`BIN_AW-1:0] peakBin,
    output logic [`CNT_W-1:0]  peakCount,
    output logic               scanDone
);

    logic               running;
    logic               cmpValid; // scanData belongs to cmpBin
    logic [`BIN_AW-1:0] cmpBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            running <= 1'b0;
            scanAddr <= '0;
            cmpValid <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            cmpValid <= running;
            scanDone <= cmpValid && (cmpBin == `NBINS - 1); // after the last compare
            if (start) begin
                running <= 1'b1;
                scanAddr <= '0;
            end else if (running) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == `NBINS - 1) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= scanAddr;
        if (start) begin
            peakBin <= '0;
            peakCount <= '0;
        end else if (cmpValid && (scanData > peakCount)) begin
            // strict compare, ties stay at the lower bin
            peakBin <= cmpBin;
            peakCount <= scanData;
        end
    end

endmodule

// ==== src/tofHistPkg.sv ====
`include "tofHist_consts.svh"

package tofHistPkg;

    typedef struct packed {
        logic [`CBIN_W-1:0]       bin;  // coarse bin
        logic [`TS_W-`CBIN_W-1:0] rest; // not used in pass 1
    } coarseView_s;

    typedef struct packed {
        logic [`CBIN_W-1:0]                tag;  // must match the coarse peak
        logic [`FBIN_W-1:0]                bin;  // fine bin inside the window
        logic [`TS_W-`CBIN_W-`FBIN_W-1:0] drop; // below fine resolution
    } fineView_s;

    // one timestamp word, read per pass
    typedef union packed {
        coarseView_s coarse;
        fineView_s   fine;
    } tsWord_u;

    typedef struct packed {
        tsWord_u ts;
        logic    last; // final timestamp of a pass
    } event_s;

    typedef struct packed {
        logic [`BIN_AW-1:0] bin;
    } binOp_s;

    typedef struct packed {
        logic [`CBIN_W-1:0] cBin;
        logic [`FBIN_W-1:0] fBin;
        logic [`CNT_W-1:0]  count; // fine peak count
    } result_s;

    typedef enum logic [2:0] {
        RESET_CLR,
        COARSE_BUILD,
        COARSE_SCAN,
        FINE_CLR,
        FINE_BUILD,
        FINE_SCAN,
        REPORT
    } phase_e;

endpackage

// ==== src/tofHistTop.sv ====
`include "tofHist_consts.svh"

module tofHistTop import tofHistPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  event_s  evIn,
    input  logic    evValid,
    output logic    evReady,
    output result_s resOut,
    output logic    resValid,
    input  logic    resReady
);

    phase_e             phase;
    logic [`CBIN_W-1:0] window;
    logic               accept;
    binOp_s             op;
    logic               opValid;
    logic               lastSeen;
    logic [`BIN_AW-1:0] scanAddr;
    logic [`CNT_W-1:0]  scanData;
    logic               clearDone;
    logic               idle;
    logic               scanStart;
    logic               scanDone;
    logic [`BIN_AW-1:0] peakBin;
    logic [`CNT_W-1:0]  peakCount;

    histSequencer seq (
        .clk       (clk),
        .res       (res),
        .evValid   (evValid),
        .lastSeen  (lastSeen),
        .clearDone (clearDone),
        .idle      (idle),
        .scanDone  (scanDone),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .resReady  (resReady),
        .phase     (phase),
        .window    (window),
        .accept    (accept),
        .evReady   (evReady),
        .scanStart (scanStart),
        .resOut    (resOut),
        .resValid  (resValid)
    );

    binDecoder dec (
        .clk      (clk),
        .res      (res),
        .phase    (phase),
        .window   (window),
        .evIn     (evIn),
        .evValid  (evValid),
        .accept   (accept),
        .op       (op),
        .opValid  (opValid),
        .lastSeen (lastSeen)
    );

    histUpdater upd (
        .clk       (clk),
        .res       (res),
        .phase     (phase),
        .op        (op),
        .opValid   (opValid),
        .scanAddr  (scanAddr),
        .scanData  (scanData),
        .clearDone (clearDone),
        .idle      (idle)
    );

    peakFinder peak (
        .clk       (clk),
        .res       (res),
        .start     (scanStart),
        .scanAddr  (scanAddr),
        .scanData  (scanData),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .scanDone  (scanDone)
    );

endmodule

// ==== src/tofHist_consts.svh ====
`ifndef TOFHIST_CONSTS_SVH
`define TOFHIST_CONSTS_SVH

// raw TDC timestamp
`define TS_W 12

// coarse bin is the top of the timestamp
`define CBIN_W 5

// fine bin sits right below the coarse field, the two lsbs are dropped
`define FBIN_W 5

// histogram geometry
`define NBINS 32
`define BIN_AW 5

// per-bin event counter
`define CNT_W 16

`endif

// ==== tests/tofHistTb.sv ====
`include "tofHist_consts.svh"

module tofHistTb import tofHistPkg::*; ();

    localparam int NFRAMES = 3;
    localparam int MAXEV = 200;
    // every pass at up to 2 cycles per event, plus clear, scan and report slack per frame
    localparam int TIMEOUT = NFRAMES * (2 * MAXEV * 2 + 5 * `NBINS) + 120;

    logic    clk = 1'b0;
    logic    res;
    event_s  evIn;
    logic    evValid;
    logic    evReady;
    result_s resOut;
    logic    resValid;
    logic    resReady;

    integer             seed;
    int                 cycles = 0;
    int                 resultCount = 0;
    int                 reportAge = 0;   // cycles the current result has been offered
    int                 frameLen [NFRAMES] = '{96, 160, 200};
    logic [`TS_W-1:0]   stamps [MAXEV];
    result_s            expectQ [$];
    logic               held = 1'b0;     // result was refused at the last edge
    result_s            heldOut;
    logic               passEnded = 1'b0;
    int                 lowCycles = 0;
    result_s            want;

    tofHistTop dut (
        .clk      (clk),
        .res      (res),
        .evIn     (evIn),
        .evValid  (evValid),
        .evReady  (evReady),
        .resOut   (resOut),
        .resValid (resValid),
        .resReady (resReady)
    );

    always #20 clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportProblem(input string msg);
        $display("error: %s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // sample the handshake mid-cycle, then move to the next rising edge
    task automatic nextEdge(output logic fired);
        @(negedge clk);
        fired = evValid && evReady;
        reportAge = resValid ? reportAge + 1 : 0;
        @(posedge clk);
        if (reportAge < 3) begin
            resReady <= 1'b0; // a new result waits a few cycles first
        end else begin
            resReady <= (($random(seed) & 3) != 0);
        end
    endtask

    // cluster around a random centre, optionally in runs of equal stamps
    task automatic makeFrame(input int n, input bit withRuns);
        int centre;
        int offset;
        int value;
        int run;
        int k;
        centre = 256 + ($unsigned($random(seed)) % 3584);
        k = 0;
        while (k < n) begin
            offset = ($random(seed) & 255) - ($random(seed) & 255);
            value = centre + offset;
            run = withRuns ? 1 + ($random(seed) & 3) : 1;
            while (run > 0 && k < n) begin
                stamps[k] = value[`TS_W-1:0];
                k++;
                run--;
            end
        end
    endtask

    // reference histograms, ties resolved to the lowest bin
    function automatic result_s expectedResult(input int n);
        int coarseHist [`NBINS];
        int fineHist [`NBINS];
        int cPeak;
        int fPeak;
        int k;
        result_s r;
        for (k = 0; k < `NBINS; k++) begin
            coarseHist[k] = 0;
            fineHist[k] = 0;
        end
        for (k = 0; k < n; k++) begin
            coarseHist[stamps[k][`TS_W-1 -: `CBIN_W]]++;
        end
        cPeak = 0;
        for (k = 1; k < `NBINS; k++) begin
            if (coarseHist[k] > coarseHist[cPeak]) cPeak = k;
        end
        for (k = 0; k < n; k++) begin
            if (stamps[k][`TS_W-1 -: `CBIN_W] == cPeak) begin
                fineHist[stamps[k][`TS_W-`CBIN_W-1 -: `FBIN_W]]++; // inside the window
            end
        end
        fPeak = 0;
        for (k = 1; k < `NBINS; k++) begin
            if (fineHist[k] > fineHist[fPeak]) fPeak = k;
        end
        r.cBin = cPeak;
        r.fBin = fPeak;
        r.count = fineHist[fPeak];
        return r;
    endfunction

    task automatic sendPass(input int n, input bit fullRate);
        int idx;
        logic fired;
        idx = 0;
        while (idx < n) begin
            nextEdge(fired);
            if (fired) idx++;
            if (fired || !evValid) begin // valid is never withdrawn before a transfer
                if (idx < n && (fullRate || (($random(seed) & 3) != 0))) begin
                    evValid <= 1'b1;
                    evIn <= {stamps[idx], idx == n - 1};
                end else begin
                    evValid <= 1'b0;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: only %0d of %0d results after %0d cycles",
                     resultCount, NFRAMES, cycles);
            $display("tests failed");
            $fatal(1, "run did not finish");
        end
    end

    always @(negedge clk) begin
        if (res) begin
            // refused result must stay put
            if (held) begin
                assert (resValid) else reportProblem("resValid dropped before the result was taken");
                assert (resOut == heldOut) else reportMismatch("resOut", resOut, heldOut);
            end
            held = resValid && !resReady;
            heldOut = resOut;

            assert (!(resValid && evReady)) else reportProblem("evReady high while a result waits");
            if (passEnded) begin
                if (evReady) begin
                    // at least one scan and one clear lie between two build phases
                    assert (lowCycles >= 2 * `NBINS)
                        else reportProblem("evReady came back too early after the last event");
                    passEnded = 1'b0;
                end else begin
                    lowCycles++;
                end
            end
            if (evValid && evReady && evIn.last) begin
                passEnded = 1'b1;
                lowCycles = 0;
            end

            if (resValid && resReady) begin
                assert (expectQ.size() > 0) else reportProblem("result with no frame outstanding");
                want = expectQ.pop_front();
                assert (resOut.cBin == want.cBin)
                    else reportMismatch("resOut.cBin", resOut.cBin, want.cBin);
                assert (resOut.fBin == want.fBin)
                    else reportMismatch("resOut.fBin", resOut.fBin, want.fBin);
                assert (resOut.count == want.count)
                    else reportMismatch("resOut.count", resOut.count, want.count);
                resultCount++;
            end
        end
    end

    initial begin
        logic fired;
        seed = 32'h9d61;
        res = 1'b0;
        evIn = '0;
        evValid = 1'b0;
        resReady = 1'b0;
        repeat (4) @(posedge clk);
        res <= 1'b1;
        for (int f = 0; f < NFRAMES; f++) begin
            makeFrame(frameLen[f], f == 0); // frame 0 hits the forwarding path
            expectQ.push_back(expectedResult(frameLen[f]));
            sendPass(frameLen[f], f == 0);
            sendPass(frameLen[f], f == 0);
        end
        while (resultCount < NFRAMES) begin
            nextEdge(fired);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
